// ==== project.f ====
+incdir+verilog
verilog/ft_bridge_pkg.sv
verilog/mem_req_if.sv
verilog/ft_sync_port.sv
verilog/host_cmd_engine.sv
verilog/reg_arbiter.sv
verilog/ft_bridge_top.sv
sim/tb_clock_gen.sv
sim/ft_chip_model.sv
sim/ft_bridge_props.sv
sim/ft_bridge_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vft_bridge_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module ft_bridge_tb -f project.f

run: compile
	./$(SIM)

clean:
	rm -rf obj_dir

// ==== sim/ft_bridge_tb.sv ====
`timescale 1ns/10ps
`include "ft_bridge_params.svh"

module ft_bridge_tb;
        import ft_bridge_pkg::*;

        localparam logic [1:0] OP_WR  = 2'd0;
        localparam logic [1:0] OP_RD  = 2'd1;
        localparam logic [1:0] OP_COL = 2'd2;  // host and local writes land in the same cycle.
        localparam int         TMO    = 200;

        typedef struct packed {
                logic       loc;
                logic [1:0] op;
                reg_addr_t  addr;
                logic [7:0] val;  // write data, or the tag of a host read.
        } row_t;

        logic       clk;
        logic       suspend_n;
        wire  [7:0] data_io;
        logic       rxf_n;
        logic       txe_n;
        logic       rd_n;
        logic       wr_n;
        logic       oe_n;
        logic       loc_req;
        logic       loc_we;
        reg_addr_t  loc_addr;
        logic [7:0] loc_wdata;
        logic [7:0] loc_rdata;
        logic       loc_done;
        logic [7:0] shadow [0:`FT_MEM_DEPTH-1];
        row_t       rows [$];
        integer     seed;

        tb_clock_gen clock_gen_i (.clk_o(clk), .suspend_n_o(suspend_n));

        ft_chip_model chip_i (
                .clk_i   (clk),
                .data_io (data_io),
                .rxf_n_o (rxf_n),
                .txe_n_i (txe_n),
                .oe_n_i  (oe_n),
                .rd_n_i  (rd_n),
                .wr_n_i  (wr_n)
        );

        ft_bridge_top ft_bridge_top_i (
                .clk_i       (clk),
                .suspend_n_i (suspend_n),
                .data_io     (data_io),
                .rxf_n_i     (rxf_n),
                .txe_n_i     (txe_n),
                .rd_n_o      (rd_n),
                .wr_n_o      (wr_n),
                .oe_n_o      (oe_n),
                .loc_req_i   (loc_req),
                .loc_we_i    (loc_we),
                .loc_addr_i  (loc_addr),
                .loc_wdata_i (loc_wdata),
                .loc_rdata_o (loc_rdata),
                .loc_done_o  (loc_done)
        );

        task automatic step();
                @(posedge clk);
                #1;
        endtask

        task automatic fail_run(input string what);
                $display("%s", what);
                $display("Done: errors found");
                $fatal(1, "simulation stopped at the first error");
        endtask

        task automatic check_pin(input string name, input logic exp, input logic got);
                if (got !== exp) begin
                        fail_run($sformatf("CHECK FAILED %s: expected %h, got %h", name, exp, got));
                end
        endtask

        task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
                if (got !== exp) begin
                        fail_run($sformatf("CHECK FAILED %s: expected %h, got %h", name, exp, got));
                end
        endtask

        task automatic check_reg(input reg_addr_t addr, input logic [7:0] exp,
                                 input logic [7:0] got);
                if (got !== exp) begin
                        fail_run($sformatf("CHECK FAILED loc_rdata_o at address %h: expected %h, got %h",
                                           addr, exp, got));
                end
        endtask

        function automatic row_t make_row(input logic loc, input logic [1:0] op,
                                          input reg_addr_t addr, input logic [7:0] val);
                return '{loc, op, addr, val};
        endfunction

        function automatic logic [7:0] fill_value(input reg_addr_t a);
                return {a, 1'b1} ^ 8'h3c;
        endfunction

        task automatic send_frame(input logic rd, input reg_addr_t addr, input logic [7:0] b);
                frame_hdr_t hdr;
                hdr.is_read = rd;
                hdr.addr    = addr;
                chip_i.push_rx(hdr);
                chip_i.push_rx(b);
        endtask

        task automatic wait_rx_drained();
                int n;
                n = 0;
                while (chip_i.rx_left() != 0 && n < TMO) begin
                        step();
                        n++;
                end
                if (chip_i.rx_left() != 0) begin
                        fail_run("timeout: the port stopped reading host bytes");
                end
        endtask

        task automatic next_tx(output logic [7:0] b);
                int n;
                n = 0;
                while (chip_i.tx_count() == 0 && n < TMO) begin
                        step();
                        n++;
                end
                if (chip_i.tx_count() == 0) begin
                        fail_run("timeout: no reply byte came out of the port");
                end
                chip_i.pop_tx(b);
        endtask

        task automatic local_access(input logic we, input reg_addr_t addr,
                                    input logic [7:0] wdata, output logic [7:0] rdata);
                int n;
                loc_req   = 1'b1;
                loc_we    = we;
                loc_addr  = addr;
                loc_wdata = wdata;
                step();
                loc_req = 1'b0;
                n = 0;
                while (!loc_done && n < TMO) begin
                        step();
                        n++;
                end
                if (!loc_done) begin
                        fail_run("timeout: the local request got no done");
                end
                rdata = loc_rdata;
        endtask

        task automatic apply_row(input row_t r);
                logic [7:0] got;
                reg_addr_t  other;
                other = r.addr ^ reg_addr_t'(1);
                case (r.op)
                OP_WR: begin
                        if (r.loc) begin
                                local_access(1'b1, r.addr, r.val, got);
                        end else begin
                                send_frame(1'b0, r.addr, r.val);
                                wait_rx_drained();
                                repeat (4) step();  // req 2 cycles after the last byte, done within 2 more.
                        end
                        shadow[r.addr] = r.val;
                end
                OP_RD: begin
                        if (r.loc) begin
                                local_access(1'b0, r.addr, 8'h00, got);
                                check_reg(r.addr, shadow[r.addr], got);
                        end else begin
                                send_frame(1'b1, r.addr, r.val);
                                next_tx(got);
                                check_byte("data_io (tag)", r.val, got);
                                next_tx(got);
                                check_byte("data_io (data)", shadow[r.addr], got);
                        end
                end
                default: begin
                        send_frame(1'b0, r.addr, r.val);
                        wait_rx_drained();
                        step();  // the host request reaches the arbiter at the next edge.
                        local_access(1'b1, other, ~r.val, got);
                        repeat (2) step();
                        shadow[r.addr] = r.val;
                        shadow[other]  = ~r.val;
                end
                endcase
        endtask

        task automatic hold_test();
                logic [7:0] got;
                int         i;
                int         taken;
                txe_n = 1'b1;
                for (i = 0; i < 6; i++) begin
                        send_frame(1'b1, reg_addr_t'(80 + i), 8'(128 + i));
                end
                for (i = 0; i < 40; i++) begin  // long enough for the port to stall.
                        step();
                        check_pin("wr_n_o", 1'b1, wr_n);
                end
                taken = 12 - chip_i.rx_left();
                if (taken > 9) begin
                        fail_run($sformatf("port took %0d bytes with no room left for replies", taken));
                end
                txe_n = 1'b0;
                for (i = 0; i < 6; i++) begin
                        next_tx(got);
                        check_byte("data_io (tag)", 8'(128 + i), got);
                        next_tx(got);
                        check_byte("data_io (data)", shadow[reg_addr_t'(80 + i)], got);
                end
        endtask

        initial begin
                int          n;
                logic [7:0]  got;
                logic [31:0] r;
                seed      = 32'h9284;
                txe_n     = 1'b0;
                loc_req   = 1'b0;
                loc_we    = 1'b0;
                loc_addr  = '0;
                loc_wdata = 8'h00;
                n = 0;
                while (!suspend_n && n < 10) begin
                        step();
                        n++;
                end
                if (!suspend_n) begin
                        fail_run("timeout: reset was never released");
                end
                check_pin("rd_n_o", 1'b1, rd_n);
                check_pin("wr_n_o", 1'b1, wr_n);
                check_pin("oe_n_o", 1'b1, oe_n);
                check_pin("loc_done_o", 1'b0, loc_done);
                repeat (4) step();
                if (chip_i.tx_count() != 0) begin
                        fail_run("a byte was written right after reset");
                end
                for (n = 0; n < `FT_MEM_DEPTH; n++) begin
                        local_access(1'b1, reg_addr_t'(n), fill_value(reg_addr_t'(n)), got);
                        shadow[n] = fill_value(reg_addr_t'(n));
                end
                rows.push_back(make_row(1'b0, OP_WR, 7'h10, 8'ha5));
                rows.push_back(make_row(1'b0, OP_RD, 7'h10, 8'h3c));
                rows.push_back(make_row(1'b1, OP_WR, 7'h22, 8'h5e));
                rows.push_back(make_row(1'b0, OP_RD, 7'h22, 8'h71));
                rows.push_back(make_row(1'b0, OP_WR, 7'h33, 8'hc4));
                rows.push_back(make_row(1'b1, OP_RD, 7'h33, 8'h00));
                rows.push_back(make_row(1'b0, OP_COL, 7'h40, 8'h9b));
                rows.push_back(make_row(1'b1, OP_RD, 7'h40, 8'h00));
                rows.push_back(make_row(1'b1, OP_RD, 7'h41, 8'h00));
                rows.push_back(make_row(1'b0, OP_RD, 7'h41, 8'h0e));
                rows.push_back(make_row(1'b0, OP_COL, 7'h46, 8'h27));  // round-robin pointer flipped.
                rows.push_back(make_row(1'b0, OP_RD, 7'h46, 8'hd2));
                rows.push_back(make_row(1'b1, OP_RD, 7'h47, 8'h00));
                foreach (rows[k]) begin
                        apply_row(rows[k]);
                end
                hold_test();
                rows.delete();
                for (n = 0; n < 40; n++) begin
                        r = $random(seed);
                        rows.push_back(make_row(r[0], (r[2:1] == 2'd3) ? OP_WR : r[2:1],
                                                r[14:8], r[23:16]));
                end
                foreach (rows[k]) begin
                        apply_row(rows[k]);
                end
                for (n = 0; n < `FT_MEM_DEPTH; n++) begin
                        local_access(1'b0, reg_addr_t'(n), 8'h00, got);
                        check_reg(reg_addr_t'(n), shadow[n], got);
                end
                $display("Done: no errors");
                $finish;
        end

endmodule

// ==== sim/ft_bridge_props.sv ====
`timescale 1ns/10ps

module ft_bridge_props (
        input logic clk_i,
        input logic suspend_n_i,
        input logic rd_n_i,
        input logic wr_n_i,
        input logic oe_n_i,
        input logic host_req_i,
        input logic host_done_i,
        input logic loc_req_i,
        input logic loc_done_i
);

        rd_wr_apart: assert property (@(posedge clk_i) disable iff (!suspend_n_i)
                rd_n_i || wr_n_i)
                else $error("rd_n and wr_n are low in the same cycle");

        rd_after_oe: assert property (@(posedge clk_i) disable iff (!suspend_n_i)
                !rd_n_i |-> !$past(oe_n_i))
                else $error("rd_n went low without oe_n low in the cycle before");

        // the DUT may only drive the bus while the chip keeps its outputs off.
        wr_bus_free: assert property (@(posedge clk_i) disable iff (!suspend_n_i)
                !wr_n_i |-> oe_n_i)
                else $error("wr_n is low while the chip drives the data bus");

        host_done_in_time: assert property (@(posedge clk_i) disable iff (!suspend_n_i)
                ($past(host_req_i, 2) && !$past(host_done_i)) |-> host_done_i)
                else $error("host memory request got no done within 2 cycles");

        loc_done_in_time: assert property (@(posedge clk_i) disable iff (!suspend_n_i)
                ($past(loc_req_i, 2) && !$past(loc_done_i)) |-> loc_done_i)
                else $error("local memory request got no done within 2 cycles");

endmodule

bind ft_bridge_top ft_bridge_props ft_bridge_props_i (
        .clk_i       (clk_i),
        .suspend_n_i (suspend_n_i),
        .rd_n_i      (rd_n_o),
        .wr_n_i      (wr_n_o),
        .oe_n_i      (oe_n_o),
        .host_req_i  (host_mem.req),
        .host_done_i (host_mem.done),
        .loc_req_i   (loc_mem.req),
        .loc_done_i  (loc_mem.done)
);

// ==== sim/ft_chip_model.sv ====
`timescale 1ns/10ps

module ft_chip_model (
        input  logic       clk_i,
        inout  wire  [7:0] data_io,
        output logic       rxf_n_o,
        input  logic       txe_n_i,
        input  logic       oe_n_i,
        input  logic       rd_n_i,
        input  logic       wr_n_i
);

        logic [7:0] rx_q [$];  // bytes waiting to go to the DUT.
        logic [7:0] tx_q [$];  // bytes the DUT has written.
        logic [7:0] head;
        logic       take;
        logic       put;
        logic [7:0] bus;

        assign data_io = oe_n_i ? 8'bz : head;

        initial begin
                rxf_n_o = 1'b1;
                head    = 8'h00;
                take    = 1'b0;
                put     = 1'b0;
                bus     = 8'h00;
        end

        // pins are settled at the falling edge and match what the DUT sees at the next rising one.
        always @(negedge clk_i) begin
                take = !rd_n_i && !rxf_n_o;
                put  = !wr_n_i && !txe_n_i;
                bus  = data_io;
        end

        always @(posedge clk_i) begin
                #0.5;
                if (take) begin
                        void'(rx_q.pop_front());
                end
                if (put) begin
                        tx_q.push_back(bus);
                end
                rxf_n_o = (rx_q.size() == 0);
                head    = (rx_q.size() == 0) ? 8'h00 : rx_q[0];
        end

        task automatic push_rx(input logic [7:0] b);
                rx_q.push_back(b);
        endtask

        task automatic pop_tx(output logic [7:0] b);
                b = tx_q.pop_front();
        endtask

        function automatic int rx_left();
                return rx_q.size();
        endfunction

        function automatic int tx_count();
                return tx_q.size();
        endfunction

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
        output logic clk_o,
        output logic suspend_n_o
);

        initial begin
                clk_o = 1'b0;
                forever #2 clk_o = ~clk_o;  // 4 ns period.
        end

        initial begin
                suspend_n_o = 1'b0;
                repeat (2) @(posedge clk_o);
                #1;
                suspend_n_o = 1'b1;
        end

endmodule

// ==== verilog/ft_bridge_top.sv ====
`timescale 1ns/10ps

module ft_bridge_top (
        input  logic                     clk_i,
        input  logic                     suspend_n_i,
        inout  wire  [7:0]               data_io,
        input  logic                     rxf_n_i,
        input  logic                     txe_n_i,
        output logic                     rd_n_o,
        output logic                     wr_n_o,
        output logic                     oe_n_o,
        input  logic                     loc_req_i,
        input  logic                     loc_we_i,
        input  ft_bridge_pkg::reg_addr_t loc_addr_i,
        input  logic [7:0]               loc_wdata_i,
        output logic [7:0]               loc_rdata_o,
        output logic                     loc_done_o
);

        logic [7:0] rx_byte;
        logic       rx_valid;
        logic       rx_hold;
        logic [7:0] tx_byte;
        logic       tx_avail;
        logic       tx_pop;

        mem_req_if host_mem ();
        mem_req_if loc_mem ();

        assign loc_mem.req   = loc_req_i;
        assign loc_mem.we    = loc_we_i;
        assign loc_mem.addr  = loc_addr_i;
        assign loc_mem.wdata = loc_wdata_i;
        assign loc_rdata_o   = loc_mem.rdata;
        assign loc_done_o    = loc_mem.done;

        ft_sync_port ft_sync_port_i (
                .clk_i       (clk_i),
                .suspend_n_i (suspend_n_i),
                .data_io     (data_io),
                .rxf_n_i     (rxf_n_i),
                .txe_n_i     (txe_n_i),
                .rd_n_o      (rd_n_o),
                .wr_n_o      (wr_n_o),
                .oe_n_o      (oe_n_o),
                .tx_byte_i   (tx_byte),
                .tx_avail_i  (tx_avail),
                .tx_pop_o    (tx_pop),
                .rx_hold_i   (rx_hold),
                .rx_byte_o   (rx_byte),
                .rx_valid_o  (rx_valid)
        );

        host_cmd_engine host_cmd_engine_i (
                .clk_i       (clk_i),
                .suspend_n_i (suspend_n_i),
                .rx_byte_i   (rx_byte),
                .rx_valid_i  (rx_valid),
                .rx_hold_o   (rx_hold),
                .tx_byte_o   (tx_byte),
                .tx_avail_o  (tx_avail),
                .tx_pop_i    (tx_pop),
                .mem         (host_mem.peer)
        );

        reg_arbiter reg_arbiter_i (
                .clk_i       (clk_i),
                .suspend_n_i (suspend_n_i),
                .host        (host_mem.arb),
                .loc         (loc_mem.arb)
        );

endmodule

// ==== verilog/reg_arbiter.sv ====
`timescale 1ns/10ps
`include "ft_bridge_params.svh"

module reg_arbiter (
        input  logic   clk_i,
        input  logic   suspend_n_i,
        mem_req_if.arb host,
        mem_req_if.arb loc
);
        import ft_bridge_pkg::*;

        logic [7:0] mem_q [0:`FT_MEM_DEPTH-1];
        logic       rr_q;  // 0 gives the host the first slot on a collision.
        logic       pend_vld_q;
        logic       pend_src_q;
        logic       pend_we_q;
        reg_addr_t  pend_addr_q;
        logic [7:0] pend_wdata_q;
        logic [7:0] rdata_q;
        logic       any_req;
        logic       both_req;
        logic       new_src;
        logic       sel_vld;
        logic       sel_src;
        logic       sel_we;
        reg_addr_t  sel_addr;
        logic [7:0] sel_wdata;
        logic       lat_vld;
        logic       lat_src;

        assign any_req  = host.req || loc.req;
        assign both_req = host.req && loc.req;
        assign new_src  = both_req ? rr_q : loc.req;  // 1 selects the local peer.

        // a latched request always goes first, so nothing waits more than one extra cycle.
        assign sel_vld   = pend_vld_q || any_req;
        assign sel_src   = pend_vld_q ? pend_src_q : new_src;
        assign sel_we    = pend_vld_q ? pend_we_q : (new_src ? loc.we : host.we);
        assign sel_addr  = pend_vld_q ? pend_addr_q : (new_src ? loc.addr : host.addr);
        assign sel_wdata = pend_vld_q ? pend_wdata_q : (new_src ? loc.wdata : host.wdata);

        assign lat_vld = pend_vld_q ? any_req : both_req;
        assign lat_src = pend_vld_q ? new_src : !rr_q;

        assign host.rdata = rdata_q;
        assign loc.rdata  = rdata_q;

        always_ff @(posedge clk_i or negedge suspend_n_i) begin
                if (!suspend_n_i) begin
                        rr_q       <= 1'b0;
                        pend_vld_q <= 1'b0;
                        host.done  <= 1'b0;
                        loc.done   <= 1'b0;
                end else begin
                        pend_vld_q <= lat_vld;
                        host.done  <= sel_vld && !sel_src;
                        loc.done   <= sel_vld && sel_src;
                        if (!pend_vld_q && both_req) begin
                                rr_q <= !rr_q;
                        end
                end
        end

        always_ff @(posedge clk_i) begin
                if (sel_vld) begin
                        if (sel_we) begin
                                mem_q[sel_addr] <= sel_wdata;
                        end
                        rdata_q <= mem_q[sel_addr];
                end
                if (lat_vld) begin
                        pend_src_q   <= lat_src;
                        pend_we_q    <= lat_src ? loc.we : host.we;
                        pend_addr_q  <= lat_src ? loc.addr : host.addr;
                        pend_wdata_q <= lat_src ? loc.wdata : host.wdata;
                end
        end

endmodule

// ==== verilog/host_cmd_engine.sv ====
`timescale 1ns/10ps
`include "ft_bridge_params.svh"

module host_cmd_engine (
        input  logic       clk_i,
        input  logic       suspend_n_i,
        input  logic [7:0] rx_byte_i,
        input  logic       rx_valid_i,
        output logic       rx_hold_o,
        output logic [7:0] tx_byte_o,
        output logic       tx_avail_o,
        input  logic       tx_pop_i,
        mem_req_if.peer    mem
);
        import ft_bridge_pkg::*;

        localparam int          QW       = $clog2(`FT_RPLQ_DEPTH);
        localparam logic [QW:0] HOLD_LVL = `FT_RPLQ_DEPTH - 4;
        localparam logic [QW:0] CNT_ONE  = 1;
        localparam logic [QW-1:0] PTR_ONE = 1;

        host_frame_u   frame_q;
        logic          phase_q;
        logic          req_q;
        logic          rd_pend_q;
        logic          push_tag;
        logic          push_data;
        logic [7:0]    rplq_mem [0:`FT_RPLQ_DEPTH-1];
        logic [QW-1:0] wr_ptr_q;
        logic [QW-1:0] rd_ptr_q;
        logic [QW-1:0] tag_ptr;
        logic [QW:0]   cnt_q;
        logic [QW:0]   cnt_nxt;

        assign mem.req   = req_q;
        assign mem.we    = !frame_q.wr.hdr.is_read;
        assign mem.addr  = frame_q.wr.hdr.addr;
        assign mem.wdata = frame_q.wr.data;

        assign push_tag  = req_q && frame_q.rd.hdr.is_read;
        assign push_data = mem.done && rd_pend_q;  // older frame, so it goes in ahead of a tag.
        assign tag_ptr   = push_data ? wr_ptr_q + PTR_ONE : wr_ptr_q;

        assign tx_byte_o  = rplq_mem[rd_ptr_q];
        assign tx_avail_o = (cnt_q != '0);
        assign rx_hold_o  = (cnt_q > HOLD_LVL);  // keep room for frames still in flight.

        always_comb begin
                cnt_nxt = cnt_q;
                if (push_data) begin
                        cnt_nxt = cnt_nxt + CNT_ONE;
                end
                if (push_tag) begin
                        cnt_nxt = cnt_nxt + CNT_ONE;
                end
                if (tx_pop_i) begin
                        cnt_nxt = cnt_nxt - CNT_ONE;
                end
        end

        always_ff @(posedge clk_i or negedge suspend_n_i) begin
                if (!suspend_n_i) begin
                        phase_q   <= 1'b0;
                        req_q     <= 1'b0;
                        rd_pend_q <= 1'b0;
                        wr_ptr_q  <= '0;
                        rd_ptr_q  <= '0;
                        cnt_q     <= '0;
                end else begin
                        if (rx_valid_i) begin
                                phase_q <= !phase_q;
                        end
                        req_q <= rx_valid_i && phase_q;  // second byte completes the frame.
                        if (req_q) begin
                                rd_pend_q <= frame_q.rd.hdr.is_read;
                        end else if (mem.done) begin
                                rd_pend_q <= 1'b0;
                        end
                        if (push_tag) begin
                                wr_ptr_q <= tag_ptr + PTR_ONE;
                        end else if (push_data) begin
                                wr_ptr_q <= wr_ptr_q + PTR_ONE;
                        end
                        if (tx_pop_i) begin
                                rd_ptr_q <= rd_ptr_q + PTR_ONE;
                        end
                        cnt_q <= cnt_nxt;
                end
        end

        always_ff @(posedge clk_i) begin
                if (rx_valid_i && !phase_q) begin
                        frame_q.wr.hdr <= frame_hdr_t'(rx_byte_i);
                end
                if (rx_valid_i && phase_q) begin
                        frame_q.wr.data <= rx_byte_i;
                end
                if (push_data) begin
                        rplq_mem[wr_ptr_q] <= mem.rdata;
                end
                if (push_tag) begin
                        rplq_mem[tag_ptr] <= frame_q.rd.tag;
                end
        end

endmodule

// ==== verilog/ft_sync_port.sv ====
`timescale 1ns/10ps

module ft_sync_port (
        input  logic       clk_i,
        input  logic       suspend_n_i,
        inout  wire  [7:0] data_io,
        input  logic       rxf_n_i,
        input  logic       txe_n_i,
        output logic       rd_n_o,
        output logic       wr_n_o,
        output logic       oe_n_o,
        input  logic [7:0] tx_byte_i,
        input  logic       tx_avail_i,
        output logic       tx_pop_o,
        input  logic       rx_hold_i,
        output logic [7:0] rx_byte_o,
        output logic       rx_valid_o
);

        localparam logic [1:0] ST_IDLE = 2'd0;
        localparam logic [1:0] ST_OE   = 2'd1;
        localparam logic [1:0] ST_READ = 2'd2;

        logic [1:0] state_q;
        logic [1:0] state_nxt;
        logic       tx_want;
        logic       rx_go;
        logic       rx_take;

        assign tx_want = !txe_n_i && tx_avail_i;
        assign rx_go   = !rxf_n_i && !rx_hold_i;
        assign rx_take = !rd_n_o && !rxf_n_i;  // the chip hands over a byte this cycle.

        always_comb begin
                state_nxt = ST_IDLE;  // pending TX always drops the read burst.
                if (!tx_want && rx_go) begin
                        state_nxt = (state_q == ST_IDLE) ? ST_OE : ST_READ;
                end
        end

        assign oe_n_o = (state_q == ST_IDLE);
        assign rd_n_o = (state_q != ST_READ);
        assign wr_n_o = !(tx_want && oe_n_o);  // wait until the chip has released the bus.

        assign tx_pop_o = !wr_n_o && !txe_n_i;
        assign data_io  = (!wr_n_o && !txe_n_i) ? tx_byte_i : 8'bz;

        always_ff @(posedge clk_i or negedge suspend_n_i) begin
                if (!suspend_n_i) begin
                        state_q    <= ST_IDLE;
                        rx_valid_o <= 1'b0;
                end else begin
                        state_q    <= state_nxt;
                        rx_valid_o <= rx_take;
                end
        end

        always_ff @(posedge clk_i) begin
                if (rx_take) begin
                        rx_byte_o <= data_io;
                end
        end

endmodule

// ==== verilog/mem_req_if.sv ====
`timescale 1ns/10ps

interface mem_req_if;
        import ft_bridge_pkg::*;

        logic       req;    // one-cycle request strobe.
        logic       we;
        reg_addr_t  addr;
        logic [7:0] wdata;
        logic [7:0] rdata;  // valid together with done.
        logic       done;   // one-cycle completion strobe.

        modport peer (
                output req, we, addr, wdata,
                input  rdata, done
        );

        modport arb (
                input  req, we, addr, wdata,
                output rdata, done
        );

endinterface

// ==== verilog/ft_bridge_pkg.sv ====
`include "ft_bridge_params.svh"

package ft_bridge_pkg;

        typedef logic [`FT_ADDR_W-1:0] reg_addr_t;

        typedef struct packed {
                logic      is_read;  // set for a read frame.
                reg_addr_t addr;
        } frame_hdr_t;

        typedef struct packed {
                frame_hdr_t hdr;
                logic [7:0] data;
        } wr_frame_t;

        typedef struct packed {
                frame_hdr_t hdr;
                logic [7:0] tag;  // echoed back ahead of the register value.
        } rd_frame_t;

        // the second byte of a host frame is either write data or a read tag.
        typedef union packed {
                wr_frame_t wr;
                rd_frame_t rd;
        } host_frame_u;

endpackage

// ==== verilog/ft_bridge_params.svh ====
`ifndef FT_BRIDGE_PARAMS_SVH
`define FT_BRIDGE_PARAMS_SVH

// register address width in bits.
`define FT_ADDR_W 7

// number of byte registers behind the arbiter.
`define FT_MEM_DEPTH 128

// reply queue slots, must be a power of two.
`define FT_RPLQ_DEPTH 8

`endif
